//--- src/dac_cmos_pkg.sv
// dac_cmos_pkg: shared sample, pin byte, mode and pair types for the CMOS DAC transmit path

package dac_cmos_pkg;

  // ********************
  // data widths
  // ********************

  // one DAC sample, signed two's complement while it is in the datapath
  typedef logic signed [15:0] sample_t;

  // one half of a sample as it is seen on the 8-bit pin bus
  typedef logic [7:0] pin_byte_t;

  // state of the PRBS-15 shift register
  typedef logic [14:0] prbs_state_t;

  // ********************
  // source selection
  // ********************

  // selects what the selector passes on to the output stage
  // any encoding not listed here sends the zero code
  typedef enum logic [2:0] {
    MODE_ZERO  = 3'd0,
    MODE_TONE  = 3'd1,
    MODE_PRBS  = 3'd2,
    MODE_SUM   = 3'd3,
    MODE_FIXED = 3'd4
  } dac_mode_t;

  // ********************
  // ddr byte pair
  // ********************

  // the two bytes of one sample, hi_byte goes out while tx_clk is high
  // and lo_byte while it is low
  typedef struct packed {
    pin_byte_t hi_byte;
    pin_byte_t lo_byte;
  } ddr_pair_t;

  // ********************
  // constants
  // ********************

  // saturation limits for the tone plus PRBS sum
  localparam sample_t SAMPLE_MAX = 16'h7fff;
  localparam sample_t SAMPLE_MIN = 16'h8000;

  // reset state of the PRBS register, all ones so the sequence never locks up
  localparam prbs_state_t PRBS_SEED = 15'h7fff;

endpackage

//--- src/dac_tone_gen.sv
// dac_tone_gen: phase accumulator that folds its phase into a signed triangle-wave sample

`timescale 1ns/100ps

module dac_tone_gen #(
  parameter int PHASE_WIDTH = 24
) (
  input  logic                   tx_clk,
  input  logic                   rst_n,
  input  logic                   tx_enable,
  input  logic [PHASE_WIDTH-1:0] tone_incr,
  output dac_cmos_pkg::sample_t  tone_sample
);

  // ********************
  // phase accumulator
  // ********************

  // the phase wraps modulo 2**PHASE_WIDTH, so the tone frequency is
  // tone_incr / 2**PHASE_WIDTH of the sample rate
  logic [PHASE_WIDTH-1:0] phase;

  // top sixteen bits of the phase, these alone decide the output
  logic [15:0] phase_top;

  // triangle value of the current phase, before the output register
  dac_cmos_pkg::sample_t fold_value;

  assign phase_top = phase[PHASE_WIDTH-1 -: 16];

  // ********************
  // triangle fold
  // ********************

  // the lower half of the phase range climbs from -32768 to 32767 and the
  // upper half comes back down, so the wave has no step at the wrap point
  function automatic dac_cmos_pkg::sample_t fold_phase(input logic [15:0] p);
    logic [15:0] shifted;
    shifted = {p[14:0], 1'b0};
    if (!p[15]) begin
      // rising half, invert the MSB to move from offset to two's complement
      fold_phase = {~shifted[15], shifted[14:0]};
    end else begin
      // falling half, the inverted ramp with its MSB inverted once more
      fold_phase = {shifted[15], ~shifted[14:0]};
    end
  endfunction

  assign fold_value = fold_phase(phase_top);

  // ********************
  // registers
  // ********************

  // phase and sample both step on an enabled edge and hold otherwise
  // the sample is taken from the phase before it advances, so it shows
  // up one cycle after the edge that produced it
  always_ff @(posedge tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase       <= '0;
      tone_sample <= '0;
    end else if (tx_enable) begin
      phase       <= phase + tone_incr;
      tone_sample <= fold_value;
    end
  end

endmodule

//--- src/dac_prbs_gen.sv
// dac_prbs_gen: PRBS-15 test pattern generator that makes sixteen new bits per clock

`timescale 1ns/100ps

module dac_prbs_gen (
  input  logic                  tx_clk,
  input  logic                  rst_n,
  input  logic                  tx_enable,
  output dac_cmos_pkg::sample_t prbs_sample
);

  // ********************
  // state
  // ********************

  // shift register for x^15 + x^14 + 1
  dac_cmos_pkg::prbs_state_t prbs_state;

  // state after sixteen single steps
  dac_cmos_pkg::prbs_state_t prbs_state_next;

  // the sixteen bits produced by those steps, first bit in the MSB
  logic [15:0] prbs_bits;

  // ********************
  // sixteen steps per clock
  // ********************

  // the loop unrolls into a small XOR network, each step feeds the
  // next one with the register shifted by one place
  always_comb begin
    dac_cmos_pkg::prbs_state_t step_state;
    logic                      new_bit;
    step_state = prbs_state;
    prbs_bits  = '0;
    for (int i = 0; i < 16; i++) begin
      // taps at bits 14 and 13, the new bit enters at bit 0
      new_bit          = step_state[14] ^ step_state[13];
      prbs_bits[15-i]  = new_bit;
      step_state       = {step_state[13:0], new_bit};
    end
    prbs_state_next = step_state;
  end

  // ********************
  // registers
  // ********************

  // the state leaves reset at the seed, so the first enabled edge gives
  // the start of the standard sequence
  always_ff @(posedge tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      prbs_state  <= dac_cmos_pkg::PRBS_SEED;
      prbs_sample <= '0;
    end else if (tx_enable) begin
      prbs_state  <= prbs_state_next;
      prbs_sample <= prbs_bits;
    end
  end

endmodule

//--- src/dac_data_sel.sv
// dac_data_sel: picks tone, PRBS, their saturated sum, a fixed word or zero, then formats it

`timescale 1ns/100ps

module dac_data_sel (
  input  logic                    tx_clk,
  input  logic                    rst_n,
  input  logic                    tx_enable,
  input  dac_cmos_pkg::dac_mode_t mode,
  input  dac_cmos_pkg::sample_t   fixed_data,
  input  logic                    offset_binary,
  input  dac_cmos_pkg::sample_t   tone_sample,
  input  dac_cmos_pkg::sample_t   prbs_sample,
  output dac_cmos_pkg::ddr_pair_t out_pair
);

  // ********************
  // saturating sum
  // ********************

  // one extra bit holds the full sum of two 16-bit signed samples
  logic [16:0] sum_wide;

  // the sum after clamping to the 16-bit range
  dac_cmos_pkg::sample_t sum_sat;

  // the chosen sample, still in two's complement
  dac_cmos_pkg::sample_t sel_sample;

  // the chosen sample in the requested output format
  dac_cmos_pkg::sample_t fmt_sample;

  // sign extend both operands by hand so the add is a plain 17-bit add
  assign sum_wide = {tone_sample[15], tone_sample} + {prbs_sample[15], prbs_sample};

  // when the two top bits differ the sum left the 16-bit range, and
  // bit 16 tells in which direction
  always_comb begin
    if (sum_wide[16] != sum_wide[15]) begin
      sum_sat = sum_wide[16] ? dac_cmos_pkg::SAMPLE_MIN : dac_cmos_pkg::SAMPLE_MAX;
    end else begin
      sum_sat = sum_wide[15:0];
    end
  end

  // ********************
  // source select
  // ********************

  always_comb begin
    case (mode)
      dac_cmos_pkg::MODE_TONE:  sel_sample = tone_sample;
      dac_cmos_pkg::MODE_PRBS:  sel_sample = prbs_sample;
      dac_cmos_pkg::MODE_SUM:   sel_sample = sum_sat;
      dac_cmos_pkg::MODE_FIXED: sel_sample = fixed_data;
      // MODE_ZERO and the unused codes
      default:                  sel_sample = '0;
    endcase
    // a disabled transmitter sends the zero code whatever the mode
    if (!tx_enable) begin
      sel_sample = '0;
    end
  end

  // offset binary is two's complement with the sign bit inverted
  assign fmt_sample = {sel_sample[15] ^ offset_binary, sel_sample[14:0]};

  // ********************
  // output register
  // ********************

  // split into the pin bytes here so the output stage only has to mux
  always_ff @(posedge tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_pair <= '0;
    end else begin
      out_pair.hi_byte <= fmt_sample[15:8];
      out_pair.lo_byte <= fmt_sample[7:0];
    end
  end

endmodule

//--- src/dac_cmos_out.sv
// dac_cmos_out: behavioural DDR output stage that sends the two bytes of a sample per clock

`timescale 1ns/100ps

module dac_cmos_out (
  input  logic                    tx_clk,
  input  logic                    rst_n,
  input  dac_cmos_pkg::ddr_pair_t out_pair,
  output dac_cmos_pkg::pin_byte_t tx_data_out
);

  // ********************
  // ddr register
  // ********************

  // stands in for eight device DDR output registers, one per pin
  // both halves are captured together on the rising edge, the way a
  // same-edge ODDR takes its two data inputs
  dac_cmos_pkg::ddr_pair_t pair_q;

  always_ff @(posedge tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_q <= '0;
    end else begin
      pair_q <= out_pair;
    end
  end

  // ********************
  // pin drive
  // ********************

  // the clock itself picks the byte, as the output mux of a DDR cell does
  // high byte during the high phase, low byte during the low phase
  // after reset both phases show zero since pair_q is cleared
  assign tx_data_out = tx_clk ? pair_q.hi_byte : pair_q.lo_byte;

  // the DAC latches the high byte on the falling edge and the low byte
  // on the next rising edge, so each byte is stable around its strobe

  // a real device would also need the pin delay taps set up, which this
  // model leaves out on purpose since the taps only shift timing and
  // never change the data order

  // note the byte order matches the pair layout, bits 15:8 first and
  // then bits 7:0, so the sample is rebuilt from two consecutive phases

endmodule

//--- src/dac_cmos_tx.sv
// dac_cmos_tx: transmit side of the CMOS DAC interface, generators through DDR pins

`timescale 1ns/100ps

module dac_cmos_tx #(
  parameter int PHASE_WIDTH = 24
) (
  input  logic                    tx_clk,
  input  logic                    rst_n,
  input  logic                    tx_enable,
  input  dac_cmos_pkg::dac_mode_t mode,
  input  logic [PHASE_WIDTH-1:0]  tone_incr,
  input  dac_cmos_pkg::sample_t   fixed_data,
  input  logic                    offset_binary,
  output dac_cmos_pkg::pin_byte_t tx_data_out
);

  // ********************
  // internal signals
  // ********************

  // samples from the two sources, both registered in their generators
  dac_cmos_pkg::sample_t   tone_sample;
  dac_cmos_pkg::sample_t   prbs_sample;

  // selected and formatted sample, already split into pin bytes
  dac_cmos_pkg::ddr_pair_t out_pair;

  // ********************
  // sample sources
  // ********************

  // triangle tone, the phase width is set here only
  dac_tone_gen #(
    .PHASE_WIDTH (PHASE_WIDTH)
  ) tone_gen_i (
    .tx_clk      (tx_clk),
    .rst_n       (rst_n),
    .tx_enable   (tx_enable),
    .tone_incr   (tone_incr),
    .tone_sample (tone_sample)
  );

  // PRBS-15 test pattern
  dac_prbs_gen prbs_gen_i (
    .tx_clk      (tx_clk),
    .rst_n       (rst_n),
    .tx_enable   (tx_enable),
    .prbs_sample (prbs_sample)
  );

  // ********************
  // select and output
  // ********************

  // one register stage from samples and controls to out_pair
  dac_data_sel data_sel_i (
    .tx_clk        (tx_clk),
    .rst_n         (rst_n),
    .tx_enable     (tx_enable),
    .mode          (mode),
    .fixed_data    (fixed_data),
    .offset_binary (offset_binary),
    .tone_sample   (tone_sample),
    .prbs_sample   (prbs_sample),
    .out_pair      (out_pair)
  );

  // one more register stage, then the bytes go out on both clock phases
  dac_cmos_out cmos_out_i (
    .tx_clk      (tx_clk),
    .rst_n       (rst_n),
    .out_pair    (out_pair),
    .tx_data_out (tx_data_out)
  );

endmodule

//--- tests/dac_cmos_tx_checker.sv
// dac_cmos_tx_checker: rebuilds samples from the DDR pins and compares them with a reference model

`timescale 1ns/100ps

module dac_cmos_tx_checker #(
  parameter int PHASE_WIDTH = 24
) (
  input  logic                    tx_clk,
  input  logic                    rst_n,
  input  logic                    tx_enable,
  input  dac_cmos_pkg::dac_mode_t mode,
  input  logic [PHASE_WIDTH-1:0]  tone_incr,
  input  dac_cmos_pkg::sample_t   fixed_data,
  input  logic                    offset_binary,
  input  dac_cmos_pkg::pin_byte_t tx_data_out,
  input  int                      test_num,
  input  logic                    test_done,
  output int                      check_count,
  output int                      error_count
);

  // the saturating sum test must see clamping in both directions
  localparam int SUM_TEST = 4;

  // ********************
  // reference functions
  // ********************

  // triangle fold of the top sixteen phase bits
  // the lower half ramps up, the upper half is the inverted ramp
  function automatic dac_cmos_pkg::sample_t ref_fold(input logic [15:0] p);
    logic [15:0] ramp;
    ramp = p << 1;
    if (p[15]) begin
      ramp = ~ramp;
    end
    ref_fold = ramp ^ 16'h8000;
  endfunction

  // sixteen single steps of x^15 + x^14 + 1, returns {new state, bits}
  // each new bit is shifted in at the bottom, so the first one ends up in the MSB
  function automatic logic [30:0] ref_prbs16(input logic [14:0] state);
    logic [15:0] bits;
    logic        fb;
    bits = '0;
    for (int n = 0; n < 16; n++) begin
      fb    = state[14] ^ state[13];
      bits  = {bits[14:0], fb};
      state = {state[13:0], fb};
    end
    ref_prbs16 = {state, bits};
  endfunction

  // source select, clamp of the sum and output format
  function automatic dac_cmos_pkg::sample_t ref_select(
    input logic                    enable,
    input dac_cmos_pkg::dac_mode_t sel_mode,
    input dac_cmos_pkg::sample_t   fixed,
    input logic                    ob,
    input dac_cmos_pkg::sample_t   tone,
    input dac_cmos_pkg::sample_t   prbs
  );
    int                    sum;
    dac_cmos_pkg::sample_t word;
    sum  = tone + prbs;
    word = '0;
    if (enable) begin
      case (sel_mode)
        dac_cmos_pkg::MODE_TONE:  word = tone;
        dac_cmos_pkg::MODE_PRBS:  word = prbs;
        dac_cmos_pkg::MODE_FIXED: word = fixed;
        dac_cmos_pkg::MODE_SUM: begin
          if (sum > dac_cmos_pkg::SAMPLE_MAX) begin
            word = dac_cmos_pkg::SAMPLE_MAX;
          end else if (sum < dac_cmos_pkg::SAMPLE_MIN) begin
            word = dac_cmos_pkg::SAMPLE_MIN;
          end else begin
            word = sum[15:0];
          end
        end
        default:                  word = '0;
      endcase
    end
    // offset binary flips the sign bit
    if (ob) begin
      word[15] = ~word[15];
    end
    ref_select = word;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       test_name = "reset and idle";
      2:       test_name = "tone";
      3:       test_name = "prbs";
      4:       test_name = "saturating sum";
      5:       test_name = "fixed and zero";
      6:       test_name = "enable gap";
      default: test_name = "unknown";
    endcase
  endfunction

  // ********************
  // model state
  // ********************

  // generator state, starting at the reset values
  logic [PHASE_WIDTH-1:0]    m_phase = '0;
  logic [14:0]               m_prbs_state = dac_cmos_pkg::PRBS_SEED;
  dac_cmos_pkg::sample_t     m_tone = '0;
  dac_cmos_pkg::sample_t     m_prbs = '0;

  // two-stage delay line, selector register then pin register
  dac_cmos_pkg::sample_t     exp_sel = '0;
  dac_cmos_pkg::sample_t     exp_pins = '0;

  // how often the expected sum clamped, high and low
  int                        clamp_hi_count = 0;
  int                        clamp_lo_count = 0;
  int                        sum_probe;

  // per-test counts, cleared when a test is reported
  int                        test_checks = 0;
  int                        test_errors = 0;
  dac_cmos_pkg::pin_byte_t   exp_byte;

  initial begin
    check_count = 0;
    error_count = 0;
  end

  // the model steps on the same edges as the DUT and resets with it
  always @(posedge tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_phase      <= '0;
      m_prbs_state <= dac_cmos_pkg::PRBS_SEED;
      m_tone       <= '0;
      m_prbs       <= '0;
      exp_sel      <= '0;
      exp_pins     <= '0;
    end else begin
      exp_pins <= exp_sel;
      exp_sel  <= ref_select(tx_enable, mode, fixed_data, offset_binary, m_tone, m_prbs);
      if (tx_enable) begin
        m_tone                 <= ref_fold(m_phase[PHASE_WIDTH-1 -: 16]);
        m_phase                <= m_phase + tone_incr;
        {m_prbs_state, m_prbs} <= ref_prbs16(m_prbs_state);
      end
      if (tx_enable && mode == dac_cmos_pkg::MODE_SUM) begin
        sum_probe = m_tone + m_prbs;
        if (sum_probe > dac_cmos_pkg::SAMPLE_MAX) begin
          clamp_hi_count <= clamp_hi_count + 1;
        end
        if (sum_probe < dac_cmos_pkg::SAMPLE_MIN) begin
          clamp_lo_count <= clamp_lo_count + 1;
        end
      end
    end
  end

  // ********************
  // pin compare
  // ********************

  // the pins are sampled well inside each phase, the high byte after the
  // rising edge and the low byte after the falling edge
  always @(posedge tx_clk or negedge tx_clk) begin
    #2.5;
    exp_byte = tx_clk ? exp_pins[15:8] : exp_pins[7:0];
    check_count++;
    test_checks++;
    if (tx_data_out !== exp_byte) begin
      error_count++;
      test_errors++;
      $display("ERROR tx_data_out test %0d %s byte at %0t: expected 0x%02h actual 0x%02h",
               test_num, tx_clk ? "hi" : "lo", $time, exp_byte, tx_data_out);
    end
    if (tx_clk && test_done) begin
      if (test_num == SUM_TEST && (clamp_hi_count == 0 || clamp_lo_count == 0)) begin
        error_count++;
        test_errors++;
        $display("test %0d did not clamp in both directions (%0d high, %0d low)",
                 test_num, clamp_hi_count, clamp_lo_count);
      end
      $display("test %0d %s: %0d checks, %0d errors",
               test_num, test_name(test_num), test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

//--- tests/dac_cmos_tx_tb.sv
// dac_cmos_tx_tb: clock, reset and test sequence for the CMOS DAC transmit path

`timescale 1ns/100ps

module dac_cmos_tx_tb;

  localparam int PHASE_WIDTH = 24;

  // ********************
  // test lengths
  // ********************

  localparam int RST_CYCLES   = 10;
  localparam int IDLE_CYCLES  = 20;
  localparam int DRAIN_CYCLES = 4;
  localparam int TONE_STEPS   = 5;
  localparam int TONE_CYCLES  = 100;
  localparam int PRBS_CYCLES  = 300;
  localparam int SUM_STEPS    = 2;
  localparam int SUM_CYCLES   = 200;
  localparam int FIXED_WORDS  = 4;
  localparam int FIXED_CYCLES = 10;
  localparam int SPAN_CYCLES  = 100;
  localparam int GAP_MAX      = 32;

  // every cycle the sequence spends, each test ends with a drain and a done pulse
  localparam int RUN_CYCLES = 2 * RST_CYCLES + 2 * IDLE_CYCLES + TONE_STEPS * TONE_CYCLES
                            + PRBS_CYCLES + SUM_STEPS * SUM_CYCLES
                            + 2 * (FIXED_WORDS + 1) * FIXED_CYCLES
                            + 2 * SPAN_CYCLES + GAP_MAX + 6 * (DRAIN_CYCLES + 1);
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES + 500;

  localparam logic [PHASE_WIDTH-1:0] HALF_PHASE = 1 << (PHASE_WIDTH - 1);

  logic                    tx_clk;
  logic                    rst_n;
  logic                    tx_enable;
  dac_cmos_pkg::dac_mode_t mode;
  logic [PHASE_WIDTH-1:0]  tone_incr;
  dac_cmos_pkg::sample_t   fixed_data;
  logic                    offset_binary;
  dac_cmos_pkg::pin_byte_t tx_data_out;
  int                      test_num;
  logic                    test_done;
  int                      check_count;
  int                      error_count;
  int                      cycle_count = 0;
  integer                  seed;

  dac_cmos_tx #(
    .PHASE_WIDTH (PHASE_WIDTH)
  ) dut_i (
    .tx_clk        (tx_clk),
    .rst_n         (rst_n),
    .tx_enable     (tx_enable),
    .mode          (mode),
    .tone_incr     (tone_incr),
    .fixed_data    (fixed_data),
    .offset_binary (offset_binary),
    .tx_data_out   (tx_data_out)
  );

  dac_cmos_tx_checker #(
    .PHASE_WIDTH (PHASE_WIDTH)
  ) checker_i (
    .tx_clk        (tx_clk),
    .rst_n         (rst_n),
    .tx_enable     (tx_enable),
    .mode          (mode),
    .tone_incr     (tone_incr),
    .fixed_data    (fixed_data),
    .offset_binary (offset_binary),
    .tx_data_out   (tx_data_out),
    .test_num      (test_num),
    .test_done     (test_done),
    .check_count   (check_count),
    .error_count   (error_count)
  );

  // ********************
  // clock and timeout
  // ********************

  initial begin
    tx_clk = 1'b0;
    forever #5 tx_clk = ~tx_clk;
  end

  always @(posedge tx_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // returns right after a falling edge, so the caller drives on that edge
  task automatic run_cycles(input int count);
    repeat (count) @(negedge tx_clk);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    run_cycles(RST_CYCLES);
    rst_n = 1'b1;
  endtask

  // lets the pipeline drain, then tells the checker the test is over
  task automatic end_test();
    run_cycles(DRAIN_CYCLES);
    test_done = 1'b1;
    run_cycles(1);
    test_done = 1'b0;
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin
    int gap;
    seed          = 32'h6a39_532b;
    rst_n         = 1'b0;
    tx_enable     = 1'b0;
    mode          = dac_cmos_pkg::MODE_ZERO;
    tone_incr     = '0;
    fixed_data    = '0;
    offset_binary = 1'b0;
    test_num      = 1;
    test_done     = 1'b0;

    // reset, then idle in both formats with the transmitter disabled
    apply_reset();
    run_cycles(IDLE_CYCLES);
    offset_binary = 1'b1;
    run_cycles(IDLE_CYCLES);
    offset_binary = 1'b0;
    end_test();

    // tone with random increments, the middle one close to half the range
    test_num  = 2;
    mode      = dac_cmos_pkg::MODE_TONE;
    tx_enable = 1'b1;
    for (int i = 0; i < TONE_STEPS; i++) begin
      tone_incr = $random(seed);
      if (i == 2) begin
        tone_incr = HALF_PHASE ^ (tone_incr & 'h3ff);
      end
      run_cycles(TONE_CYCLES);
    end
    end_test();

    // a fresh reset so the PRBS starts from its seed
    test_num = 3;
    mode     = dac_cmos_pkg::MODE_PRBS;
    apply_reset();
    run_cycles(PRBS_CYCLES);
    end_test();

    // steps of 1/8 to 1/4 of the phase range swing the tone hard into both limits
    test_num = 4;
    mode     = dac_cmos_pkg::MODE_SUM;
    for (int i = 0; i < SUM_STEPS; i++) begin
      tone_incr = $random(seed);
      tone_incr[PHASE_WIDTH-1 -: 3] = 3'b001;
      run_cycles(SUM_CYCLES);
    end
    end_test();

    // fixed words and zero, in two's complement and then offset binary
    test_num = 5;
    for (int fmt = 0; fmt < 2; fmt++) begin
      offset_binary = fmt[0];
      mode          = dac_cmos_pkg::MODE_FIXED;
      for (int w = 0; w < FIXED_WORDS; w++) begin
        fixed_data = $random(seed);
        run_cycles(FIXED_CYCLES);
      end
      mode = dac_cmos_pkg::MODE_ZERO;
      run_cycles(FIXED_CYCLES);
    end
    offset_binary = 1'b0;
    end_test();

    // the enable drops for a random span in the middle of the sum
    test_num  = 6;
    mode      = dac_cmos_pkg::MODE_SUM;
    tone_incr = $random(seed);
    run_cycles(SPAN_CYCLES);
    gap       = 5 + ($unsigned($random(seed)) % (GAP_MAX - 4));
    tx_enable = 1'b0;
    run_cycles(gap);
    tx_enable = 1'b1;
    run_cycles(SPAN_CYCLES);
    end_test();

    $display("run complete: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sources.f
src/dac_cmos_pkg.sv
src/dac_tone_gen.sv
src/dac_prbs_gen.sv
src/dac_data_sel.sv
src/dac_cmos_out.sv
src/dac_cmos_tx.sv
tests/dac_cmos_tx_checker.sv
tests/dac_cmos_tx_tb.sv

//--- Bender.yml
package:
  name: dac_cmos_tx

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - files:
      - src/dac_cmos_pkg.sv
      - src/dac_tone_gen.sv
      - src/dac_prbs_gen.sv
      - src/dac_data_sel.sv
      - src/dac_cmos_out.sv
      - src/dac_cmos_tx.sv

  # testbench with its checker
  - target: test
    files:
      - tests/dac_cmos_tx_checker.sv
      - tests/dac_cmos_tx_tb.sv
